// File: compile.f
rtl/oledPkg.sv
rtl/frameCapture.sv
rtl/refreshSequencer.sv
rtl/busWriter.sv
rtl/oledCtrl.sv
sim/clockGen.sv
sim/oledCtrl_assertions.sv
sim/oledCtrlTb.sv

// File: rtl/busWriter.sv
`timescale 1ns/100ps
`default_nettype none

module busWriter
	import oledPkg::*;
(
	input wire logic CLOCK,
	input wire logic RST_n,
	input wire logic issue,
	input wire writeReq_t nextReq,
	input wire logic busDone,
	output logic call,
	output writeReq_t req,
	output logic complete
);

	// busDone counts only against a write that is actually out
	assign complete = call && busDone;

	// req only loads on issue, so it holds for the whole call
	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			call <= 1'b0;
			req <= '0;
		end else if (issue) begin
			req <= nextReq;
			call <= 1'b1;
		end else if (complete) begin
			call <= 1'b0; // low for at least one cycle before next issue
		end
	end

endmodule

`default_nettype wire

// File: rtl/frameCapture.sv
`timescale 1ns/100ps
`default_nettype none

module frameCapture
	import oledPkg::*;
(
	input wire logic CLOCK,
	input wire logic RST_n,
	input wire logic capture,
	input wire frameImage_t frame,
	input wire pixelSel_t pixelSel,
	output logic [7:0] pixelByte
);

	frameImage_t snapshot;
	pageImage_t selPage;

	// whole frame is loaded in one edge so a refresh never mixes two images
	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			snapshot <= '0; // blank panel until the first capture
		end else if (capture) begin
			snapshot <= frame;
		end
	end

	always_comb begin
		selPage = snapshot[pixelSel.page];
		pixelByte = selPage[pixelSel.column];
	end

endmodule

`default_nettype wire

// File: rtl/oledCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module oledCtrl
	import oledPkg::*;
#(
	parameter int POWER_UP_CYCLES = 125
) (
	input wire logic CLOCK,
	input wire logic RST_n,
	input wire logic run,
	input wire frameImage_t frame,
	input wire logic busDone,
	output logic call,
	output writeReq_t req,
	output logic done
);

	logic issue;
	writeReq_t nextReq;
	logic complete;
	logic capture;
	pixelSel_t pixelSel;
	logic [7:0] pixelByte;

	frameCapture frameCapture_i (
		.CLOCK(CLOCK),
		.RST_n(RST_n),
		.capture(capture),
		.frame(frame),
		.pixelSel(pixelSel),
		.pixelByte(pixelByte)
	);

	refreshSequencer #(
		.POWER_UP_CYCLES(POWER_UP_CYCLES)
	) refreshSequencer_i (
		.CLOCK(CLOCK),
		.RST_n(RST_n),
		.run(run),
		.complete(complete),
		.pixelByte(pixelByte),
		.issue(issue),
		.nextReq(nextReq),
		.capture(capture),
		.pixelSel(pixelSel),
		.done(done)
	);

	busWriter busWriter_i (
		.CLOCK(CLOCK),
		.RST_n(RST_n),
		.issue(issue),
		.nextReq(nextReq),
		.busDone(busDone),
		.call(call),
		.req(req),
		.complete(complete)
	);

endmodule

`default_nettype wire

// File: rtl/oledPkg.sv
`default_nettype none

package oledPkg;

	localparam int PAGE_COUNT = 4;
	localparam int PAGE_BYTES = 128;
	localparam int INIT_LEN = 23;

	// control bytes ahead of every payload byte
	localparam logic [7:0] CTRL_CMD = 8'h00;
	localparam logic [7:0] CTRL_DATA = 8'h40;

	localparam logic [7:0] PAGE_BASE = 8'hB0; // page p -> B0 + p
	localparam logic [7:0] COL_LOW_CMD = 8'h00;
	localparam logic [7:0] COL_HIGH_CMD = 8'h10;

	// byte j of a page sits at bits 8j+7:8j
	typedef logic [PAGE_BYTES-1:0][7:0] pageImage_t;
	typedef pageImage_t [PAGE_COUNT-1:0] frameImage_t;

	typedef struct packed {
		logic [1:0] page;
		logic [6:0] column;
	} pixelSel_t;

	typedef struct packed {
		logic [7:0] ctrlByte;
		logic [7:0] dataByte;
	} writeReq_t;

	// panel bring-up list, sent in order with CTRL_CMD
	function automatic logic [7:0] initCommand(input logic [4:0] index);
		logic [7:0] cmd;
		case (index)
			5'd0: cmd = 8'hAE; // display off
			5'd1: cmd = 8'h40; // start line 0
			5'd2: cmd = 8'hB0;
			5'd3: cmd = 8'hC8; // com scan remapped
			5'd4: cmd = 8'h81; // contrast
			5'd5: cmd = 8'hFF;
			5'd6: cmd = 8'hA1; // segment remap
			5'd7: cmd = 8'hA6; // normal, not inverted
			5'd8: cmd = 8'hA8; // multiplex ratio
			5'd9: cmd = 8'h1F; // 32 rows
			5'd10: cmd = 8'hD3; // display offset
			5'd11: cmd = 8'h00;
			5'd12: cmd = 8'hD5; // osc divide
			5'd13: cmd = 8'hF0;
			5'd14: cmd = 8'hD9; // precharge
			5'd15: cmd = 8'h22;
			5'd16: cmd = 8'hDA; // com pins
			5'd17: cmd = 8'h02;
			5'd18: cmd = 8'hDB; // vcomh
			5'd19: cmd = 8'h49;
			5'd20: cmd = 8'h8D; // charge pump
			5'd21: cmd = 8'h14;
			5'd22: cmd = 8'hAF; // display on
			default: cmd = 8'hE3; // nop
		endcase
		return cmd;
	endfunction

endpackage

`default_nettype wire

// File: rtl/refreshSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module refreshSequencer
	import oledPkg::*;
#(
	parameter int POWER_UP_CYCLES = 125
) (
	input wire logic CLOCK,
	input wire logic RST_n,
	input wire logic run,
	input wire logic complete,
	input wire logic [7:0] pixelByte,
	output logic issue,
	output writeReq_t nextReq,
	output logic capture,
	output pixelSel_t pixelSel,
	output logic done
);

	localparam int WAIT_W = $clog2(POWER_UP_CYCLES + 1);
	localparam logic [WAIT_W-1:0] LAST_WAIT = WAIT_W'(POWER_UP_CYCLES - 1);
	localparam logic [4:0] LAST_INIT = 5'(INIT_LEN - 1);
	localparam logic [6:0] LAST_COLUMN = 7'(PAGE_BYTES - 1);
	localparam logic [1:0] LAST_PAGE = 2'(PAGE_COUNT - 1);

	// state names the write that goes out next
	localparam logic [2:0] ST_WAIT = 3'd0;
	localparam logic [2:0] ST_INIT = 3'd1;
	localparam logic [2:0] ST_PAGE = 3'd2;
	localparam logic [2:0] ST_COL_LOW = 3'd3;
	localparam logic [2:0] ST_COL_HIGH = 3'd4;
	localparam logic [2:0] ST_PIXEL = 3'd5;

	logic [2:0] state;
	logic [WAIT_W-1:0] waitCnt;
	logic [4:0] initIdx;
	logic [1:0] pageIdx;
	logic [6:0] columnIdx;
	logic pending; // next write ready, not yet handed over
	logic lastInit;
	logic lastPixel;

	assign lastInit = (state == ST_INIT) && (initIdx == LAST_INIT);
	assign lastPixel = (state == ST_PIXEL) && (columnIdx == LAST_COLUMN);

	assign issue = pending && run;

	// new snapshot lands on the edge before the page-0 address command
	assign capture = complete && (lastInit || (lastPixel && pageIdx == LAST_PAGE));

	assign pixelSel = '{page: pageIdx, column: columnIdx};

	always_comb begin
		nextReq = '0;
		case (state)
			ST_INIT: begin
				nextReq.ctrlByte = CTRL_CMD;
				nextReq.dataByte = initCommand(initIdx);
			end
			ST_PAGE: begin
				nextReq.ctrlByte = CTRL_CMD;
				nextReq.dataByte = PAGE_BASE + {6'd0, pageIdx};
			end
			ST_COL_LOW: begin
				nextReq.ctrlByte = CTRL_CMD;
				nextReq.dataByte = COL_LOW_CMD;
			end
			ST_COL_HIGH: begin
				nextReq.ctrlByte = CTRL_CMD;
				nextReq.dataByte = COL_HIGH_CMD;
			end
			ST_PIXEL: begin
				nextReq.ctrlByte = CTRL_DATA;
				nextReq.dataByte = pixelByte; // byte of the current column
			end
			default: nextReq = '0;
		endcase
	end

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			state <= ST_WAIT;
			waitCnt <= '0;
			initIdx <= '0;
			pageIdx <= '0;
			columnIdx <= '0;
			pending <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (issue) begin
				pending <= 1'b0;
			end
			if (state == ST_WAIT) begin
				if (run) begin // power-up wait only counts while running
					if (waitCnt == LAST_WAIT) begin
						state <= ST_INIT;
						pending <= 1'b1;
					end else begin
						waitCnt <= waitCnt + 1'b1;
					end
				end
			end else if (complete) begin
				pending <= 1'b1;
				case (state)
					ST_INIT: begin
						if (lastInit) begin
							state <= ST_PAGE;
							pageIdx <= '0;
							done <= 1'b1;
						end else begin
							initIdx <= initIdx + 1'b1;
						end
					end
					ST_PAGE: state <= ST_COL_LOW;
					ST_COL_LOW: state <= ST_COL_HIGH;
					ST_COL_HIGH: begin
						state <= ST_PIXEL;
						columnIdx <= '0;
					end
					ST_PIXEL: begin
						if (lastPixel) begin
							state <= ST_PAGE;
							done <= 1'b1; // end of page
							if (pageIdx == LAST_PAGE) begin
								pageIdx <= '0;
							end else begin
								pageIdx <= pageIdx + 1'b1;
							end
						end else begin
							columnIdx <= columnIdx + 1'b1;
						end
					end
					default: state <= ST_WAIT;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the OLED controller testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module oledCtrlTb -f compile.f -o oledCtrlSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output="$(./obj_dir/oledCtrlSim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "NO ERRORS" <<< "$output"; then
	exit 0
fi
exit 1

// File: sim/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 3
) (
	output logic CLOCK,
	output logic RST_n
);

	initial begin
		CLOCK = 1'b0;
		forever #(PERIOD_NS / 2) CLOCK = ~CLOCK;
	end

	// release lands just after an edge, like the other stimulus
	initial begin
		RST_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLOCK);
		#1 RST_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: sim/oledCtrlTb.sv
`timescale 1ns/100ps
`default_nettype none

module oledCtrlTb
	import oledPkg::*;
();

	localparam int POWER_UP = 60;
	localparam int PERIOD_NS = 8;
	localparam int RESET_CYCLES = 3;
	localparam int WRITE_BUDGET = 23 + 3 * 4 * 131; // init plus three frames
	localparam int WATCHDOG_NS = WRITE_BUDGET * 45 * PERIOD_NS
		+ (POWER_UP + RESET_CYCLES + 10) * PERIOD_NS;
	localparam logic [7:0] INIT_LIST [23] = '{
		8'hAE, 8'h40, 8'hB0, 8'hC8, 8'h81, 8'hFF, 8'hA1, 8'hA6, 8'hA8, 8'h1F, 8'hD3, 8'h00,
		8'hD5, 8'hF0, 8'hD9, 8'h22, 8'hDA, 8'h02, 8'hDB, 8'h49, 8'h8D, 8'h14, 8'hAF};

	logic CLOCK;
	logic RST_n;
	logic run;
	frameImage_t frame;
	logic busDone;
	logic call;
	writeReq_t req;
	logic done;

	writeReq_t reqLog[$]; // every write the bus accepted
	writeReq_t expectQ[$];
	int doneLog[$]; // write count seen at each done pulse
	int doneExpect[$];
	int checkedWrites = 0;
	int checkedDones = 0;
	int errorCount = 0;
	int testErrors = 0;
	int testCount = 0;
	string curTest = "";
	logic [31:0] rngState = 32'h5d94_294f;
	int maxDelay = 8;
	frameImage_t imageA;
	frameImage_t imageB;

	clockGen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) clockGen_i (
		.CLOCK(CLOCK),
		.RST_n(RST_n)
	);

	oledCtrl #(.POWER_UP_CYCLES(POWER_UP)) oledCtrl_i (
		.CLOCK(CLOCK),
		.RST_n(RST_n),
		.run(run),
		.frame(frame),
		.busDone(busDone),
		.call(call),
		.req(req),
		.done(done)
	);

	bind oledCtrl oledCtrl_assertions oledCtrlAssertions_i (
		.CLOCK(CLOCK),
		.RST_n(RST_n),
		.call(call),
		.busDone(busDone),
		.done(done),
		.req(req)
	);

	function automatic logic [31:0] xorshiftNext();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	task automatic nextCycle();
		@(posedge CLOCK);
		#1;
	endtask

	task automatic checkValue(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error in test %s, %s: expected %h, actual %h",
				curTest, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic reportFailure(input string text);
		$display("Failure in test %s: %s", curTest, text);
		testErrors++;
	endtask

	task automatic startTest(input string name);
		curTest = name;
		testErrors = 0;
	endtask

	task automatic finishTest();
		$display("Test %s finished with %0d errors", curTest, testErrors);
		errorCount += testErrors;
		testCount++;
	endtask

	task automatic fillRandomFrame(output frameImage_t img);
		logic [31:0] rnd;
		for (int p = 0; p < 4; p++) begin
			for (int j = 0; j < 128; j++) begin
				rnd = xorshiftNext();
				img[p][j] = rnd[7:0];
			end
		end
	endtask

	task automatic expectWrite(input logic [7:0] ctrl, input logic [7:0] data);
		writeReq_t w;
		w.ctrlByte = ctrl;
		w.dataByte = data;
		expectQ.push_back(w);
	endtask

	// page command, column low, column high, 128 data bytes, then done
	task automatic expectFrame(input frameImage_t img);
		for (int p = 0; p < 4; p++) begin
			expectWrite(8'h00, 8'hB0 + 8'(p));
			expectWrite(8'h00, 8'h00);
			expectWrite(8'h00, 8'h10);
			for (int j = 0; j < 128; j++) begin
				expectWrite(8'h40, img[p][j]);
			end
			doneExpect.push_back(expectQ.size());
		end
	endtask

	task automatic waitForWrites(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (reqLog.size() < count && cycles < limit) begin
			nextCycle();
			cycles++;
		end
		if (reqLog.size() < count)
			reportFailure($sformatf("only %0d of %0d writes arrived in time",
				reqLog.size(), count));
	endtask

	task automatic compareStream();
		int limit;
		int cycles;
		limit = (expectQ.size() - checkedWrites) * (maxDelay + 4) + POWER_UP + 100;
		waitForWrites(expectQ.size(), limit);
		cycles = 0;
		while (doneLog.size() < doneExpect.size() && cycles < 10) begin
			nextCycle();
			cycles++;
		end
		if (doneLog.size() < doneExpect.size())
			reportFailure("a done pulse is missing");
		for (int i = checkedWrites; i < expectQ.size() && i < reqLog.size(); i++)
			checkValue($sformatf("write %0d", i), 32'(expectQ[i]), 32'(reqLog[i]));
		for (int i = checkedDones; i < doneExpect.size() && i < doneLog.size(); i++)
			checkValue($sformatf("done %0d after write count", i), doneExpect[i], doneLog[i]);
		checkedWrites = expectQ.size();
		checkedDones = doneExpect.size();
	endtask

	task automatic resetBehaviour();
		startTest("reset");
		repeat (2) begin
			nextCycle();
			checkValue("call in reset", 0, 32'(call));
			checkValue("done in reset", 0, 32'(done));
			checkValue("req in reset", 0, 32'(req));
		end
		while (RST_n !== 1'b1) nextCycle();
		repeat (POWER_UP - 2) begin // still inside the power-up wait
			checkValue("call after reset", 0, 32'(call));
			checkValue("done after reset", 0, 32'(done));
			checkValue("req after reset", 0, 32'(req));
			nextCycle();
		end
		finishTest();
	endtask

	task automatic initSequence();
		startTest("initialisation");
		for (int i = 0; i < 23; i++) expectWrite(8'h00, INIT_LIST[i]);
		doneExpect.push_back(23);
		compareStream();
		finishTest();
	endtask

	task automatic pageRefresh();
		startTest("page refresh");
		expectFrame(imageA);
		compareStream();
		finishTest();
	endtask

	task automatic frameSnapshot();
		startTest("snapshot");
		expectFrame(imageA); // change comes mid frame, so old image stays
		expectFrame(imageB);
		waitForWrites(checkedWrites + 131 + 40, 171 * (maxDelay + 4));
		frame = imageB;
		compareStream();
		finishTest();
	endtask

	task automatic backPressurePause();
		logic prevCall;
		startTest("back-pressure and pause");
		maxDelay = 40;
		expectFrame(imageB);
		waitForWrites(checkedWrites + 300, 300 * (maxDelay + 4));
		run = 1'b0;
		prevCall = call;
		repeat (200) begin
			nextCycle();
			if (call && !prevCall)
				reportFailure("call started while run was low");
			prevCall = call;
		end
		run = 1'b1;
		compareStream();
		finishTest();
	endtask

	// bus model, answers each call after a random delay
	initial begin
		int delay;
		logic [31:0] rnd;
		busDone = 1'b0;
		forever begin
			nextCycle();
			if (RST_n && call) begin
				rnd = xorshiftNext();
				delay = 1 + int'(rnd % 32'(maxDelay));
				repeat (delay - 1) nextCycle();
				busDone = 1'b1;
				reqLog.push_back(req);
				nextCycle();
				busDone = 1'b0;
			end
		end
	end

	initial begin
		forever begin
			nextCycle();
			if (RST_n && done) doneLog.push_back(reqLog.size());
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d writes", reqLog.size());
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		run = 1'b1;
		fillRandomFrame(imageA);
		fillRandomFrame(imageB);
		frame = imageA;
		resetBehaviour();
		initSequence();
		pageRefresh();
		frameSnapshot();
		backPressurePause();
		if (oledCtrl_i.oledCtrlAssertions_i.failCount != 0)
			$display("Bus protocol assertions failed %0d times",
				oledCtrl_i.oledCtrlAssertions_i.failCount);
		errorCount += oledCtrl_i.oledCtrlAssertions_i.failCount;
		$display("Summary: %0d tests, %0d errors", testCount, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/oledCtrl_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module oledCtrl_assertions
	import oledPkg::*;
(
	input wire logic CLOCK,
	input wire logic RST_n,
	input wire logic call,
	input wire logic busDone,
	input wire logic done,
	input wire writeReq_t req
);

	int failCount = 0; // failures so far, summed by the testbench

	// bus still working on it, so req must hold
	reqHeld: assert property (@(posedge CLOCK) disable iff (!RST_n)
		call && !busDone |=> $stable(req))
		else begin
			failCount++;
			$error("req changed during an open write");
		end

	callDrops: assert property (@(posedge CLOCK) disable iff (!RST_n)
		busDone |=> !call)
		else begin
			failCount++;
			$error("call still high the cycle after busDone");
		end

	noDoneInReset: assert property (@(posedge CLOCK) !RST_n |-> !done)
		else begin
			failCount++;
			$error("done pulsed while reset was active");
		end

endmodule

`default_nettype wire
